//--- Makefile
# Verilator build and run of the polynomial unit testbench

VERILATOR ?= verilator
TOP       ?= tb_poly_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard *.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
poly_pkg.sv
poly_mem_if.sv
poly_ram.sv
mem_arbiter.sv
mod_arith.sv
pwo_engine.sv
poly_top.sv
tb_clkgen.sv
tb_poly_top.sv

//--- mem_arbiter.sv
// Fixed-priority arbiter between the pointwise engine and the host port
// Engine always wins, a colliding host strobe is dropped and flagged
`default_nettype none

module mem_arbiter
    import poly_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    poly_mem_if.slave        eng,
    poly_mem_if.slave        host,
    output logic             ram_en,
    output logic             ram_we,
    output addr_t            ram_addr,
    output coeff_t           ram_wdata,
    input  coeff_t           ram_rdata,
    output logic             host_collision
);

    logic host_gnt;
    // Owner tags of the read in flight
    logic rd_eng_q;
    logic rd_host_q;

    //======================================================================
    // Request select
    //======================================================================
    assign host_gnt = host.req && !eng.req;

    always_comb begin
        ram_en    = eng.req || host.req;
        ram_we    = eng.req ? eng.we : host.we;
        ram_addr  = eng.req ? eng.addr : host.addr;
        ram_wdata = eng.req ? eng.wdata : host.wdata;
    end

    // Dropped host strobe, same cycle
    assign host_collision = host.req && eng.req;

    //======================================================================
    // Read return
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_eng_q  <= 1'b0;
            rd_host_q <= 1'b0;
        end else begin
            rd_eng_q  <= eng.req && !eng.we;
            rd_host_q <= host_gnt && !host.we;
        end
    end

    // RAM data goes to both, rvalid marks the owner
    assign eng.rvalid  = rd_eng_q;
    assign eng.rdata   = ram_rdata;
    assign host.rvalid = rd_host_q;
    assign host.rdata  = ram_rdata;

    a_rvalid_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) !(eng.rvalid && host.rvalid)
    ) else $error("read data returned to both ports");

endmodule

`default_nettype wire

//--- mod_arith.sv
// Modular add, subtract and Barrett multiply modulo POLY_Q
// Add and subtract take one cycle, multiply takes two, paths run independently
`default_nettype none

module mod_arith
    import poly_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  pwo_op_t op,
    input  coeff_t  a,
    input  coeff_t  b,
    output logic    out_valid,
    output coeff_t  result
);

    // Add and subtract path
    logic [COEFF_W:0]   sum;
    logic [COEFF_W:0]   diff;
    coeff_t             add_d;
    logic               add_valid_q;
    coeff_t             add_q;

    // Multiply path
    logic [PROD_W-1:0]  prod_d;
    logic               mul_valid_q;
    logic [PROD_W-1:0]  prod_q;
    logic [PROD_W+COEFF_W-1:0] prod_mu;
    coeff_t             qhat;
    logic [PROD_W-1:0]  qhat_q;
    logic [PROD_W-1:0]  rem_wide;
    logic [COEFF_W:0]   rem;
    coeff_t             red_d;
    logic               red_valid_q;
    coeff_t             red_q;

    //======================================================================
    // Add and subtract, one correction by Q
    //======================================================================
    always_comb begin
        sum  = {1'b0, a} + {1'b0, b};
        diff = {1'b0, a} - {1'b0, b};
        if (op == pws) begin
            // Borrow out means a < b
            add_d = diff[COEFF_W] ? COEFF_W'(diff + {1'b0, POLY_Q}) : diff[COEFF_W-1:0];
        end else begin
            add_d = (sum >= {1'b0, POLY_Q}) ? COEFF_W'(sum - {1'b0, POLY_Q})
                                             : sum[COEFF_W-1:0];
        end
    end

    //======================================================================
    // Barrett multiply
    //======================================================================
    // Operands are reduced, so the top bit is always zero
    assign prod_d = a[COEFF_W-2:0] * b[COEFF_W-2:0];

    // Quotient estimate, low by at most one
    always_comb begin
        prod_mu  = prod_q * BARRETT_MU;
        qhat     = prod_mu[PROD_W+COEFF_W-1:PROD_W];
        qhat_q   = qhat * POLY_Q;
        rem_wide = prod_q - qhat_q;
        // Remainder below 2Q, fits in COEFF_W+1 bits
        rem      = rem_wide[COEFF_W:0];
        red_d    = (rem >= {1'b0, POLY_Q}) ? COEFF_W'(rem - {1'b0, POLY_Q})
                                           : rem[COEFF_W-1:0];
    end

    //======================================================================
    // Valid pipeline
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            add_valid_q <= 1'b0;
            mul_valid_q <= 1'b0;
            red_valid_q <= 1'b0;
        end else begin
            add_valid_q <= in_valid && (op != pwm);
            mul_valid_q <= in_valid && (op == pwm);
            red_valid_q <= mul_valid_q;
        end
    end

    // Payload stages
    always_ff @(posedge clk) begin
        if (in_valid && (op != pwm)) begin
            add_q <= add_d;
        end
        if (in_valid && (op == pwm)) begin
            prod_q <= prod_d;
        end
        if (mul_valid_q) begin
            red_q <= red_d;
        end
    end

    assign out_valid = add_valid_q || red_valid_q;
    assign result    = red_valid_q ? red_q : add_q;

    a_result_reduced : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> (result < POLY_Q)
    ) else $error("result not reduced below Q");

    // Caller must not finish an add in the cycle a multiply retires
    a_no_retire_clash : assert property (
        @(posedge clk) disable iff (!rst_n) !(add_valid_q && red_valid_q)
    ) else $error("add and multiply results retire together");

endmodule

`default_nettype wire

//--- poly_mem_if.sv
// One request port into the shared coefficient RAM
// Requesters use the master modport, the arbiter the slave modport
`default_nettype none

interface poly_mem_if
    import poly_pkg::*;
();

    // Request side, one-cycle strobe
    logic   req;
    logic   we;
    addr_t  addr;
    coeff_t wdata;

    // Return side, one cycle after a granted read
    coeff_t rdata;
    logic   rvalid;

    modport master (
        output req, we, addr, wdata,
        input  rdata, rvalid
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, rvalid
    );

endinterface

`default_nettype wire

//--- poly_pkg.sv
// Shared constants and types for the polynomial coefficient unit
// Import with poly_pkg::* in any module that needs the modulus or the types
`default_nettype none

package poly_pkg;

    //======================================================================
    // Sizes
    //======================================================================
    localparam int unsigned POLY_N  = 32;
    localparam int unsigned COEFF_W = 24;
    localparam int unsigned ADDR_W  = 7;
    // Coefficient index width
    localparam int unsigned IDX_W   = $clog2(POLY_N);
    // Full product of two reduced coefficients, Q^2 < 2^46
    localparam int unsigned PROD_W  = 2 * (COEFF_W - 1);

    typedef logic [COEFF_W-1:0] coeff_t;
    typedef logic [ADDR_W-1:0]  addr_t;

    //======================================================================
    // Modulus and reduction
    //======================================================================
    localparam coeff_t POLY_Q     = 24'd8380417;
    // floor(2^46 / Q)
    localparam coeff_t BARRETT_MU = 24'd8396807;

    // Region bases, one polynomial per region
    localparam addr_t BASE_A = 7'd0;
    localparam addr_t BASE_B = 7'd32;
    localparam addr_t BASE_C = 7'd64;

    // Pointwise operations
    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } pwo_op_t;

endpackage

`default_nettype wire

//--- poly_ram.sv
// Single-port coefficient RAM with registered read data
// Reset and zeroize clear every word and the read register
`default_nettype none

module poly_ram #(
    parameter int ADDR_W = 7,
    parameter int DATA_W = 24
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              zeroize,
    input  logic              en,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    // Write has no read-through, rdata holds during writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else if (zeroize) begin
            // Wipe secret material
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    // Zeroize would silently swallow a write
    a_no_write_in_zeroize : assert property (
        @(posedge clk) disable iff (!rst_n) zeroize |-> !(en && we)
    ) else $error("write strobe during zeroize");

endmodule

`default_nettype wire

//--- poly_top.sv
// Top level of the polynomial coefficient unit
// Host port and pointwise engine share one RAM through the arbiter
`default_nettype none

module poly_top
    import poly_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    zeroize,
    input  logic    start,
    input  pwo_op_t op,
    input  logic    accumulate,
    input  logic    host_req,
    input  logic    host_we,
    input  addr_t   host_addr,
    input  coeff_t  host_wdata,
    output coeff_t  host_rdata,
    output logic    host_rvalid,
    output logic    host_collision,
    output logic    busy,
    output logic    done
);

    // RAM side of the arbiter
    logic   ram_en;
    logic   ram_we;
    addr_t  ram_addr;
    coeff_t ram_wdata;
    coeff_t ram_rdata;

    poly_mem_if eng_bus ();
    poly_mem_if host_bus ();

    //======================================================================
    // Host port onto its bus
    //======================================================================
    assign host_bus.req   = host_req;
    assign host_bus.we    = host_we;
    assign host_bus.addr  = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_rdata     = host_bus.rdata;
    assign host_rvalid    = host_bus.rvalid;

    pwo_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op         (op),
        .accumulate (accumulate),
        .bus        (eng_bus.master),
        .busy       (busy),
        .done       (done)
    );

    mem_arbiter u_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .eng            (eng_bus.slave),
        .host           (host_bus.slave),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata),
        .host_collision (host_collision)
    );

    // A, B and C regions in one array
    poly_ram #(
        .ADDR_W (ADDR_W),
        .DATA_W (COEFF_W)
    ) u_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .en      (ram_en),
        .we      (ram_we),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .rdata   (ram_rdata)
    );

endmodule

`default_nettype wire

//--- pwo_engine.sv
// Pointwise operation sequencer over the N coefficients
// Reads A and B, optionally old C, computes through mod_arith and writes C
`default_nettype none

module pwo_engine
    import poly_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  pwo_op_t    op,
    input  logic       accumulate,
    poly_mem_if.master bus,
    output logic       busy,
    output logic       done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_A,
        S_RD_B,
        S_OP,
        S_WAIT,
        S_ACC
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;
    logic             last;
    pwo_op_t          op_q;
    logic             acc_q;

    // Operand holding
    coeff_t           a_q;
    coeff_t           c_q;
    coeff_t           c_val;

    // Arithmetic unit hookup
    logic             arith_valid;
    pwo_op_t          arith_op;
    coeff_t           arith_a;
    coeff_t           arith_b;
    logic             arith_out_valid;
    coeff_t           arith_result;
    logic             wr_fire;

    assign last = (idx == IDX_W'(POLY_N - 1));
    assign busy = (state != S_IDLE);

    // Old C may arrive together with an add result
    assign c_val = bus.rvalid ? bus.rdata : c_q;

    // Result is ready to store
    assign wr_fire = arith_out_valid &&
                     (((state == S_WAIT) && !acc_q) || (state == S_ACC));

    //======================================================================
    // Arithmetic feed
    //======================================================================
    always_comb begin
        if (state == S_OP) begin
            // B read data is on the bus this cycle
            arith_valid = 1'b1;
            arith_op    = op_q;
            arith_a     = a_q;
            arith_b     = bus.rdata;
        end else begin
            // Second pass adds the old C
            arith_valid = (state == S_WAIT) && acc_q && arith_out_valid;
            arith_op    = pwa;
            arith_a     = arith_result;
            arith_b     = c_val;
        end
    end

    mod_arith u_mod_arith (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (arith_valid),
        .op        (arith_op),
        .a         (arith_a),
        .b         (arith_b),
        .out_valid (arith_out_valid),
        .result    (arith_result)
    );

    //======================================================================
    // Memory requests
    //======================================================================
    always_comb begin
        bus.req   = 1'b0;
        bus.we    = 1'b0;
        bus.addr  = BASE_C + addr_t'(idx);
        bus.wdata = arith_result;
        unique case (state)
            S_RD_A: begin
                bus.req  = 1'b1;
                bus.addr = BASE_A + addr_t'(idx);
            end
            S_RD_B: begin
                bus.req  = 1'b1;
                bus.addr = BASE_B + addr_t'(idx);
            end
            // Old C only when accumulating
            S_OP: bus.req = acc_q;
            S_WAIT, S_ACC: begin
                bus.req = wr_fire;
                bus.we  = wr_fire;
            end
            default: ;
        endcase
    end

    //======================================================================
    // Sequencer
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            idx   <= '0;
            op_q  <= pwm;
            acc_q <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            unique case (state)
                S_IDLE: begin
                    if (start) begin
                        op_q  <= op;
                        acc_q <= accumulate;
                        idx   <= '0;
                        state <= S_RD_A;
                    end
                end
                S_RD_A: state <= S_RD_B;
                S_RD_B: state <= S_OP;
                S_OP:   state <= S_WAIT;
                S_WAIT: begin
                    if (arith_out_valid && acc_q) begin
                        state <= S_ACC;
                    end
                end
                default: ;
            endcase
            // Store of C ends the index
            if (wr_fire) begin
                if (last) begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end else begin
                    idx   <= idx + 1'b1;
                    state <= S_RD_A;
                end
            end
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if ((state == S_RD_B) && bus.rvalid) begin
            a_q <= bus.rdata;
        end
        if ((state == S_WAIT) && bus.rvalid) begin
            c_q <= bus.rdata;
        end
    end

    a_idle_quiet : assert property (
        @(posedge clk) disable iff (!rst_n) (state == S_IDLE) |-> !bus.req
    ) else $error("engine request while idle");

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// Testbench clock and reset source for the polynomial unit
// 8 ns clock, rst_n held low for the first 4 rising edges
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam realtime HALF_PERIOD = 4ns;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        // Release on an edge, like any other driven input
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

//--- tb_poly_top.sv
// Directed testbench for poly_top
// Host loads and reads the RAM, engine runs pwa, pws and pwm, results checked
// against a coefficient model of the whole RAM kept in the testbench
`default_nettype none

module tb_poly_top
    import poly_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    //======================================================================
    // Limits and DUT signals
    //======================================================================
    localparam int MEM_WORDS   = 2 ** ADDR_W;
    localparam int DONE_LIMIT  = POLY_N * 8;
    localparam int CYCLE_LIMIT = 6 * POLY_N * 8 + 200;
    // Free words above C, used for colliding host writes
    localparam int SPARE_BASE  = 96;
    localparam int SPARE_CNT   = 24;

    logic    clk;
    logic    rst_n;
    logic    zeroize;
    logic    start;
    pwo_op_t eng_op;
    logic    accumulate;
    logic    host_req;
    logic    host_we;
    addr_t   host_addr;
    coeff_t  host_wdata;
    coeff_t  host_rdata;
    logic    host_rvalid;
    logic    host_collision;
    logic    busy;
    logic    done;

    // Expected RAM contents
    coeff_t      mem_ref [MEM_WORDS];
    logic [15:0] lfsr_state;
    int          coeff_errs;
    int          flag_errs;
    int          proto_errs;
    int          cycles = 0;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    poly_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .zeroize        (zeroize),
        .start          (start),
        .op             (eng_op),
        .accumulate     (accumulate),
        .host_req       (host_req),
        .host_we        (host_we),
        .host_addr      (host_addr),
        .host_wdata     (host_wdata),
        .host_rdata     (host_rdata),
        .host_rvalid    (host_rvalid),
        .host_collision (host_collision),
        .busy           (busy),
        .done           (done)
    );

    //======================================================================
    // Stimulus source and reference model
    //======================================================================
    // x^16 + x^14 + x^13 + x^11 + 1, one bit per step
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    // 23 random bits, folded below Q
    function automatic coeff_t rand_coeff();
        logic [22:0] v;
        v = '0;
        for (int i = 0; i < 23; i++) begin
            v = {v[21:0], lfsr_bit()};
        end
        if (v >= POLY_Q) begin
            v = v - 23'(POLY_Q);
        end
        return coeff_t'(v);
    endfunction

    function automatic coeff_t ref_op(input pwo_op_t o, input coeff_t a, input coeff_t b);
        longint q;
        q = longint'(POLY_Q);
        case (o)
            pwa:     return coeff_t'((longint'(a) + longint'(b)) % q);
            // Shift up by Q first, never negative
            pws:     return coeff_t'((longint'(a) + q - longint'(b)) % q);
            default: return coeff_t'((longint'(a) * longint'(b)) % q);
        endcase
    endfunction

    // C region after one engine run
    task automatic update_model(input pwo_op_t o, input bit acc);
        coeff_t r;
        for (int i = 0; i < POLY_N; i++) begin
            r = ref_op(o, mem_ref[int'(BASE_A) + i], mem_ref[int'(BASE_B) + i]);
            if (acc) begin
                r = ref_op(pwa, r, mem_ref[int'(BASE_C) + i]);
            end
            mem_ref[int'(BASE_C) + i] = r;
        end
    endtask

    //======================================================================
    // Compare tasks
    //======================================================================
    task automatic check_coeff(input addr_t addr, input coeff_t exp, input coeff_t act);
        if (act !== exp) begin
            coeff_errs++;
            $display("ERR host_rdata addr=%h exp=%h act=%h", addr, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            flag_errs++;
            $display("ERR %s exp=%h act=%h", name, exp, act);
        end
    endtask

    //======================================================================
    // Host port access
    //======================================================================
    // One strobe per cycle, collision sampled mid-cycle
    task automatic host_write(input addr_t addr, input coeff_t data, output bit collided);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(negedge clk);
        collided = host_collision;
    endtask

    task automatic host_idle();
        @(posedge clk);
        host_req <= 1'b0;
        host_we  <= 1'b0;
    endtask

    // Writes the model words of a region, engine idle
    task automatic write_region(input int base, input int count);
        bit col;
        for (int i = 0; i < count; i++) begin
            host_write(addr_t'(base + i), mem_ref[base + i], col);
            check_flag("host_collision", 1'b0, col);
        end
        host_idle();
    endtask

    // Back-to-back reads, each answered on the next cycle
    task automatic read_block(input int base, input int count);
        for (int i = 0; i <= count; i++) begin
            @(posedge clk);
            if (i < count) begin
                host_req  <= 1'b1;
                host_we   <= 1'b0;
                host_addr <= addr_t'(base + i);
            end else begin
                host_req <= 1'b0;
            end
            @(negedge clk);
            if (i == 0) begin
                if (host_rvalid) begin
                    proto_errs++;
                    $display("host_rvalid came in the same cycle as the read");
                end
            end else if (!host_rvalid) begin
                proto_errs++;
                $display("No host_rvalid for the read of address %h", base + i - 1);
            end else begin
                check_coeff(addr_t'(base + i - 1), mem_ref[base + i - 1], host_rdata);
            end
        end
        @(negedge clk);
        if (host_rvalid) begin
            proto_errs++;
            $display("host_rvalid stayed high after the last read");
        end
    endtask

    //======================================================================
    // Engine control
    //======================================================================
    task automatic start_engine(input pwo_op_t o, input bit acc);
        @(posedge clk);
        start      <= 1'b1;
        eng_op     <= o;
        accumulate <= acc;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (!busy) begin
            proto_errs++;
            $display("Engine did not go busy after start");
        end
    endtask

    // Done is one cycle wide and busy drops with it
    task automatic wait_done();
        int waited;
        bit got;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < DONE_LIMIT) begin
            @(negedge clk);
            waited++;
            got = done;
        end
        if (!got) begin
            proto_errs++;
            $display("Engine never signalled done");
        end else begin
            check_flag("busy", 1'b0, busy);
            @(negedge clk);
            check_flag("done", 1'b0, done);
        end
    endtask

    task automatic run_engine(input pwo_op_t o, input bit acc);
        start_engine(o, acc);
        wait_done();
        update_model(o, acc);
    endtask

    task automatic fill_random(input int base);
        for (int i = 0; i < POLY_N; i++) begin
            mem_ref[base + i] = rand_coeff();
        end
    endtask

    //======================================================================
    // Directed tests
    //======================================================================
    task automatic test_load_readback();
        fill_random(BASE_A);
        fill_random(BASE_B);
        // Forces a wrapping sum in the next test
        mem_ref[BASE_A] = POLY_Q - 1;
        mem_ref[BASE_B] = POLY_Q - 1;
        write_region(BASE_A, 2 * POLY_N);
        read_block(BASE_A, 2 * POLY_N);
    endtask

    task automatic test_pwa();
        run_engine(pwa, 1'b0);
        read_block(BASE_C, POLY_N);
    endtask

    task automatic test_pws();
        coeff_t x;
        coeff_t y;
        coeff_t t;
        for (int i = 0; i < POLY_N; i++) begin
            x = rand_coeff();
            y = rand_coeff();
            if (x > y) begin
                t = x;
                x = y;
                y = t;
            end
            // B strictly above A
            if (x == y) begin
                if (y < POLY_Q - 1) y = y + 1;
                else x = x - 1;
            end
            mem_ref[int'(BASE_A) + i] = x;
            mem_ref[int'(BASE_B) + i] = y;
        end
        write_region(BASE_A, 2 * POLY_N);
        run_engine(pws, 1'b0);
        read_block(BASE_C, POLY_N);
    endtask

    task automatic test_pwm();
        fill_random(BASE_A);
        fill_random(BASE_B);
        // Largest product
        mem_ref[BASE_A] = POLY_Q - 1;
        mem_ref[BASE_B] = POLY_Q - 1;
        write_region(BASE_A, 2 * POLY_N);
        run_engine(pwm, 1'b0);
        read_block(BASE_C, POLY_N);
    endtask

    // Two accumulating runs over a zero C give twice the product
    task automatic test_pwm_accumulate();
        for (int i = 0; i < POLY_N; i++) begin
            mem_ref[int'(BASE_C) + i] = '0;
        end
        write_region(BASE_C, POLY_N);
        run_engine(pwm, 1'b1);
        run_engine(pwm, 1'b1);
        read_block(BASE_C, POLY_N);
    endtask

    task automatic test_collision_zeroize();
        coeff_t val;
        bit     col;
        int     dropped;
        dropped = 0;
        start_engine(pwa, 1'b0);
        // Spare words, only the granted writes land
        for (int i = 0; i < SPARE_CNT; i++) begin
            val = rand_coeff();
            if (val == '0) val = 1;
            host_write(addr_t'(SPARE_BASE + i), val, col);
            if (col) dropped++;
            else mem_ref[SPARE_BASE + i] = val;
        end
        host_idle();
        check_flag("host_collision", 1'b1, dropped > 0);
        wait_done();
        update_model(pwa, 1'b0);
        read_block(BASE_C, POLY_N);
        read_block(SPARE_BASE, SPARE_CNT);
        // Clear pulse, then every word reads zero
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_ref[i] = '0;
        end
        read_block(0, MEM_WORDS);
    endtask

    //======================================================================
    // Run control
    //======================================================================
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        zeroize    = 1'b0;
        start      = 1'b0;
        eng_op     = pwm;
        accumulate = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lfsr_state = 16'd2;
        coeff_errs = 0;
        flag_errs  = 0;
        proto_errs = 0;
        // Reset clears the RAM
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_ref[i] = '0;
        end
        @(posedge rst_n);
        repeat (2) @(posedge clk);

        test_load_readback();
        test_pwa();
        test_pws();
        test_pwm();
        test_pwm_accumulate();
        test_collision_zeroize();

        $display("Errors: coeff %0d, flag %0d, protocol %0d", coeff_errs, flag_errs,
                 proto_errs);
        if (coeff_errs + flag_errs + proto_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
